// ==== Bender.yml ====
package:
  name: lsu_lane

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_isa_pkg.sv
      - hw/lsu_pkg.sv
      - hw/data_ram.sv
      - hw/lsu_protect_regs.sv
      - hw/lsu_lane_align.sv
      - hw/lsu_top.sv
  - target: simulation
    include_dirs:
      - hw
      - bench
    files:
      - bench/lsu_tb.sv

// ==== bench/lsu_tb_checks.svh ====
`ifndef LSU_TB_CHECKS_SVH
`define LSU_TB_CHECKS_SVH

// ********************
// expected behavior
// ********************
// fault rule for one request, from the RV32 encodings.
function automatic logic fault_expected(input rv_isa_pkg::opcode_t op,
                                        input rv_isa_pkg::funct3_t f3,
                                        input lsu_pkg::addr_t addr);
    logic is_ld;
    logic is_st;
    int   nbytes;
    is_ld = (op == rv_isa_pkg::OP_LOAD);
    is_st = (op == rv_isa_pkg::OP_STORE);
    case (f3)
        3'b000:  nbytes = 1;              // lb and sb.
        3'b001:  nbytes = 2;              // lh and sh.
        3'b010:  nbytes = 4;              // lw and sw.
        3'b100:  nbytes = is_ld ? 1 : 0;  // lbu has no store form.
        3'b101:  nbytes = is_ld ? 2 : 0;  // lhu has no store form.
        default: nbytes = 0;
    endcase
    if (!is_ld && !is_st)
        return 1'b1;
    if (nbytes == 0)
        return 1'b1;  // no such access.
    if (int'(addr) % nbytes != 0)
        return 1'b1;
    return is_st && (addr < limit_model);
endfunction

// little-endian read of the shadow bytes.
function automatic lsu_pkg::data_t load_value(input rv_isa_pkg::funct3_t f3,
                                              input lsu_pkg::addr_t addr);
    logic [7:0]  b;
    logic [15:0] h;
    b = shadow[addr];
    h = {shadow[addr + 1], shadow[addr]};
    case (f3[1:0])
        rv_isa_pkg::SZ_BYTE: return f3[2] ? {24'h0, b} : {{24{b[7]}}, b};
        rv_isa_pkg::SZ_HALF: return f3[2] ? {16'h0, h} : {{16{h[15]}}, h};
        default:             return {shadow[addr + 3], shadow[addr + 2], h};
    endcase
endfunction

task automatic shadow_store(input rv_isa_pkg::funct3_t f3, input lsu_pkg::addr_t addr,
                            input lsu_pkg::data_t wdata);
    shadow[addr] = wdata[7:0];
    if (f3[1:0] != rv_isa_pkg::SZ_BYTE) shadow[addr + 1] = wdata[15:8];
    if (f3[1:0] == rv_isa_pkg::SZ_WORD) begin
        shadow[addr + 2] = wdata[23:16];
        shadow[addr + 3] = wdata[31:24];
    end
endtask

task automatic report_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    $display("[FAIL] %0t ns: %0s expected %h actual %h", $time, name, exp, got);
    errors++;
endtask

// ********************
// request drivers
// ********************
// expectation is worked out before the shadow changes.
task automatic issue(input rv_isa_pkg::opcode_t op, input rv_isa_pkg::funct3_t f3,
                     input lsu_pkg::addr_t addr, input lsu_pkg::data_t wdata);
    lsu_pkg::lsu_rsp_t e;
    e.valid   = 1'b1;
    e.is_load = (op == rv_isa_pkg::OP_LOAD);
    e.fault   = fault_expected(op, f3, addr);
    e.rdata   = (e.is_load && !e.fault) ? load_value(f3, addr) : '0;
    if (op == rv_isa_pkg::OP_STORE && !e.fault) shadow_store(f3, addr, wdata);
    if (e.fault) fault_count++;
    @(negedge clk);
    req      = '{valid: 1'b1, opcode: op, funct3: f3, addr: addr, wdata: wdata};
    exp_next = e;
endtask

task automatic idle(input int n);
    repeat (n) begin
        @(negedge clk);
        req      = '0;
        cfg      = '0;
        exp_next = '0;
    end
endtask

task automatic cfg_write(input lsu_pkg::addr_t limit);
    idle(1);
    cfg = '{we: 1'b1, wdata: limit};
    @(negedge clk);
    cfg         = '0;
    limit_model = limit;  // in force from the next request on.
endtask

// count in the upper half and limit in the lower.
task automatic check_cfg();
    logic [31:0] exp;
    idle(3);
    exp = {fault_count[15:0], 4'h0, limit_model};
    assert (cfg_rdata === exp) else report_mismatch("cfg_rdata", exp, cfg_rdata);
endtask

`endif

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;

    localparam int WIN_WORDS  = 64;      // test window, bytes 0x000..0x0ff.
    localparam int N_RAND_ST  = 40;
    localparam int PROT_LIMIT = 'h080;
    localparam int TOTAL_REQS = 2 * WIN_WORDS + N_RAND_ST + 8 * 15 + 20 + 19 + 16;
    localparam longint WATCHDOG_NS = longint'(TOTAL_REQS + 150) * 100;

    localparam rv_isa_pkg::funct3_t F3_B  = {1'b0, rv_isa_pkg::SZ_BYTE};
    localparam rv_isa_pkg::funct3_t F3_H  = {1'b0, rv_isa_pkg::SZ_HALF};
    localparam rv_isa_pkg::funct3_t F3_W  = {1'b0, rv_isa_pkg::SZ_WORD};
    localparam rv_isa_pkg::funct3_t F3_BU = {1'b1, rv_isa_pkg::SZ_BYTE};
    localparam rv_isa_pkg::funct3_t F3_HU = {1'b1, rv_isa_pkg::SZ_HALF};

    logic              clk;
    logic              arst_n;
    lsu_pkg::lsu_req_t req;
    lsu_pkg::cfg_t     cfg;
    lsu_pkg::lsu_rsp_t rsp;
    lsu_pkg::data_t    cfg_rdata;

    lsu_pkg::lsu_rsp_t exp_next;  // for the request being driven.
    lsu_pkg::lsu_rsp_t exp_now;   // for the response on the bus now.
    logic [7:0]        shadow [1 << `LSU_ADDR_W];
    logic [31:0]       lfsr_q = 32'h748f6755;
    lsu_pkg::addr_t    limit_model;
    int                fault_count;
    int                errors;
    int                err_mark;
    int                tests_pass;
    int                tests_fail;

    `include "lsu_tb_checks.svh"

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic end_test(input string name);
        idle(3);
        if (errors == err_mark) begin
            tests_pass++;
            $display("test %0s: ok", name);
        end else begin
            tests_fail++;
            $display("test %0s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    lsu_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .cfg       (cfg),
        .rsp       (rsp),
        .cfg_rdata (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ********************
    // response checker
    // ********************
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) exp_now <= '0;
        else         exp_now <= exp_next;
    end

    always @(negedge clk) begin
        if (arst_n) begin
            assert (rsp.valid === exp_now.valid)
                else report_mismatch("rsp.valid", exp_now.valid, rsp.valid);
            if (exp_now.valid) begin
                assert (rsp.is_load === exp_now.is_load)
                    else report_mismatch("rsp.is_load", exp_now.is_load, rsp.is_load);
                assert (rsp.fault === exp_now.fault)
                    else report_mismatch("rsp.fault", exp_now.fault, rsp.fault);
                assert (rsp.rdata === exp_now.rdata)
                    else report_mismatch("rsp.rdata", exp_now.rdata, rsp.rdata);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    // ********************
    // test sequence
    // ********************
    initial begin
        lsu_pkg::addr_t      a;
        logic [1:0]          kind;
        rv_isa_pkg::funct3_t f3;
        arst_n = 1'b0;
        req = '0;
        cfg = '0;
        exp_next = '0;
        limit_model = '0;
        fault_count = 0;
        errors = 0;
        err_mark = 0;
        tests_pass = 0;
        tests_fail = 0;
        repeat (5) @(posedge clk);
        @(negedge clk) arst_n = 1'b1;

        idle(2);
        assert (rsp.valid === 1'b0) else report_mismatch("rsp.valid", 0, rsp.valid);
        assert (rsp.fault === 1'b0) else report_mismatch("rsp.fault", 0, rsp.fault);
        assert (cfg_rdata === '0) else report_mismatch("cfg_rdata", 0, cfg_rdata);
        end_test("reset state");

        for (int i = 0; i < WIN_WORDS; i++)
            issue(rv_isa_pkg::OP_STORE, F3_W, lsu_pkg::addr_t'(i * 4), lfsr_bits(32));
        for (int i = 0; i < N_RAND_ST; i++) begin
            kind = lfsr_bits(2);
            a    = lsu_pkg::addr_t'(lfsr_bits(8));
            f3   = F3_B;
            if (kind == 2'd1) begin
                f3   = F3_H;
                a[0] = 1'b0;
            end else if (kind == 2'd2) begin
                f3     = F3_W;
                a[1:0] = 2'b00;
            end
            issue(rv_isa_pkg::OP_STORE, f3, a, lfsr_bits(32));
        end
        for (int i = 0; i < WIN_WORDS; i++)
            issue(rv_isa_pkg::OP_LOAD, F3_W, lsu_pkg::addr_t'(i * 4), '0);
        end_test("aligned stores");

        for (int i = 0; i < 8; i++) begin
            a = lsu_pkg::addr_t'(lfsr_bits(6) << 2);
            for (int o = 0; o < 4; o++) begin
                issue(rv_isa_pkg::OP_LOAD, F3_B, a + o, '0);
                issue(rv_isa_pkg::OP_LOAD, F3_BU, a + o, '0);
            end
            for (int o = 0; o < 4; o += 2) begin
                issue(rv_isa_pkg::OP_LOAD, F3_H, a + o, '0);
                issue(rv_isa_pkg::OP_LOAD, F3_HU, a + o, '0);
            end
            issue(rv_isa_pkg::OP_LOAD, F3_W, a, '0);
            issue(rv_isa_pkg::OP_STORE, F3_H, a + 2, lfsr_bits(32));  // load right behind.
            issue(rv_isa_pkg::OP_LOAD, F3_HU, a + 2, '0);
        end
        end_test("load extension");

        a = lsu_pkg::addr_t'(lfsr_bits(6) << 2);
        for (int o = 1; o < 4; o++) begin
            issue(rv_isa_pkg::OP_LOAD, F3_W, a + o, '0);
            issue(rv_isa_pkg::OP_STORE, F3_W, a + o, lfsr_bits(32));
        end
        for (int o = 1; o < 4; o += 2) begin
            issue(rv_isa_pkg::OP_LOAD, F3_H, a + o, '0);
            issue(rv_isa_pkg::OP_LOAD, F3_HU, a + o, '0);
            issue(rv_isa_pkg::OP_STORE, F3_H, a + o, lfsr_bits(32));
        end
        issue(rv_isa_pkg::OP_LOAD, 3'b011, a, '0);
        issue(rv_isa_pkg::OP_LOAD, 3'b110, a, '0);
        issue(rv_isa_pkg::OP_LOAD, 3'b111, a, '0);
        issue(rv_isa_pkg::OP_STORE, 3'b100, a, lfsr_bits(32));
        issue(rv_isa_pkg::OP_STORE, 3'b011, a, lfsr_bits(32));
        issue(rv_isa_pkg::OP_STORE, 3'b101, a, lfsr_bits(32));
        issue(7'b0110011, F3_W, a, lfsr_bits(32));
        issue(rv_isa_pkg::OP_LOAD, F3_W, a, '0);  // word still as before.
        end_test("faults");

        cfg_write(lsu_pkg::addr_t'(PROT_LIMIT));
        check_cfg();
        for (int i = 0; i < 4; i++) begin
            a = lsu_pkg::addr_t'(lfsr_bits(5) << 2);
            issue(rv_isa_pkg::OP_STORE, F3_W, a, lfsr_bits(32));
            issue(rv_isa_pkg::OP_LOAD, F3_W, a, '0);
            a = lsu_pkg::addr_t'(PROT_LIMIT + lfsr_bits(7));
            issue(rv_isa_pkg::OP_STORE, F3_B, a, lfsr_bits(32));
            issue(rv_isa_pkg::OP_LOAD, F3_BU, a, '0);
        end
        issue(rv_isa_pkg::OP_STORE, F3_B, lsu_pkg::addr_t'(PROT_LIMIT - 1), lfsr_bits(32));
        issue(rv_isa_pkg::OP_STORE, F3_W, lsu_pkg::addr_t'(PROT_LIMIT), lfsr_bits(32));
        issue(rv_isa_pkg::OP_LOAD, F3_W, lsu_pkg::addr_t'(PROT_LIMIT), '0);
        check_cfg();
        cfg_write('0);
        check_cfg();
        end_test("write protect");

        for (int i = 0; i < 16; i++) begin
            a = lsu_pkg::addr_t'(lfsr_bits(6) << 2);
            if (i % 2) issue(rv_isa_pkg::OP_LOAD, F3_B, a + lfsr_bits(2), '0);
            else       issue(rv_isa_pkg::OP_LOAD, F3_W, a, '0);
        end
        end_test("back-to-back loads");

        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_pass, tests_fail, errors);
        if (tests_fail == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hw
+incdir+bench
hw/rv_isa_pkg.sv
hw/lsu_pkg.sv
hw/data_ram.sv
hw/lsu_protect_regs.sv
hw/lsu_lane_align.sv
hw/lsu_top.sv
bench/lsu_tb.sv

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

// word-wide RAM, byte-lane write and registered read.
module data_ram #(
    parameter int WORDS = `LSU_RAM_WORDS
) (
    input  logic             clk,
    input  lsu_pkg::ram_wr_t wr,
    input  lsu_pkg::widx_t   raddr,
    output lsu_pkg::data_t   rdata
);

    lsu_pkg::data_t mem [WORDS];

    // ********************
    // write port
    // ********************
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wr.be[b]) begin
                mem[wr.widx][b*8 +: 8] <= wr.wdata[b*8 +: 8];
            end
        end
    end

    // ********************
    // read port
    // ********************
    // same-edge collision returns the old word.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== hw/lsu_lane_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_lane_align (
    input  logic               clk,
    input  logic               arst_n,
    input  lsu_pkg::lsu_req_t  req,
    input  lsu_pkg::addr_t     protect_limit,
    output lsu_pkg::ram_wr_t   ram_wr,
    output lsu_pkg::widx_t     ram_raddr,
    input  lsu_pkg::data_t     ram_rdata,
    output lsu_pkg::lsu_rsp_t  rsp,
    output logic               fault_pulse
);

    // ********************
    // request decode
    // ********************
    logic                is_load;
    logic                is_store;
    rv_isa_pkg::size_t   size;
    logic                uns;
    logic [1:0]          byte_idx;

    logic                misaligned;
    logic                bad_funct3;
    logic                bad_opcode;
    logic                protected_hit;
    logic                fault;

    lsu_pkg::byte_en_t   be;
    lsu_pkg::data_t      st_data;

    assign is_load  = (req.opcode == rv_isa_pkg::OP_LOAD);
    assign is_store = (req.opcode == rv_isa_pkg::OP_STORE);
    assign size     = req.funct3[1:0];
    assign uns      = req.funct3[rv_isa_pkg::F3_UNSIGNED_BIT];
    assign byte_idx = req.addr[1:0];

    // ********************
    // fault check
    // ********************
    always_comb begin
        case (size)
            rv_isa_pkg::SZ_HALF: misaligned = byte_idx[0];
            rv_isa_pkg::SZ_WORD: misaligned = |byte_idx;
            default:             misaligned = 1'b0;
        endcase
    end

    // size 11 never exists; stores have no unsigned form, neither does lw on RV32.
    assign bad_funct3 = (size == 2'b11) ||
                        (uns && (is_store || size == rv_isa_pkg::SZ_WORD));
    assign bad_opcode    = !is_load && !is_store;
    assign protected_hit = is_store && (req.addr < protect_limit); // limit 0 never hits.
    assign fault = req.valid && (misaligned || bad_funct3 || bad_opcode || protected_hit);

    // ********************
    // store lane steering
    // ********************
    always_comb begin
        case (size)
            rv_isa_pkg::SZ_BYTE: begin
                st_data = {4{req.wdata[7:0]}};  // byte in every lane.
                be      = 4'b0001 << byte_idx;
            end
            rv_isa_pkg::SZ_HALF: begin
                st_data = {2{req.wdata[15:0]}};
                be      = byte_idx[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_data = req.wdata;
                be      = 4'b1111;
            end
        endcase
    end

    assign ram_wr.be    = (req.valid && is_store && !fault) ? be : 4'b0000;
    assign ram_wr.widx  = req.addr[`LSU_ADDR_W-1:2];
    assign ram_wr.wdata = st_data;

    // RAM read runs every cycle, only loads use the word.
    assign ram_raddr = req.addr[`LSU_ADDR_W-1:2];

    // ********************
    // response stage
    // ********************
    logic                rsp_valid_q;
    logic                is_load_q;
    logic                fault_q;
    logic [1:0]          byte_idx_q;  // index of the address that fetched ram_rdata.
    rv_isa_pkg::funct3_t funct3_q;

    logic                uns_q;
    lsu_pkg::data_t      lane;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid_q <= 1'b0;
            is_load_q   <= 1'b0;
            fault_q     <= 1'b0;
        end else begin
            rsp_valid_q <= req.valid;
            is_load_q   <= req.valid && is_load;
            fault_q     <= fault;
        end
    end

    always_ff @(posedge clk) begin
        byte_idx_q <= byte_idx;
        funct3_q   <= req.funct3;
    end

    assign uns_q = funct3_q[rv_isa_pkg::F3_UNSIGNED_BIT];
    assign lane  = ram_rdata >> {byte_idx_q, 3'b000}; // addressed lane down to bit 0.

    always_comb begin
        rsp.valid   = rsp_valid_q;
        rsp.is_load = is_load_q;
        rsp.fault   = fault_q;
        if (!is_load_q || fault_q) begin
            rsp.rdata = '0;
        end else begin
            case (funct3_q[1:0])
                rv_isa_pkg::SZ_BYTE: rsp.rdata = {{24{!uns_q & lane[7]}}, lane[7:0]};
                rv_isa_pkg::SZ_HALF: rsp.rdata = {{16{!uns_q & lane[15]}}, lane[15:0]};
                rv_isa_pkg::SZ_WORD: rsp.rdata = lane;
                default:             rsp.rdata = '0;
            endcase
        end
    end

    assign fault_pulse = fault_q; // one cycle, alongside the response.

endmodule

`default_nettype wire

// ==== hw/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// ********************
// unit dimensions.
// ********************

// byte address width, covers the whole data RAM.
`define LSU_ADDR_W 12

// RAM depth in 32-bit words.
`define LSU_RAM_WORDS 1024

// fault counter width; fills the upper half of cfg_rdata.
`define LSU_FCNT_W 16

// word index width, byte address minus the lane bits.
`define LSU_WIDX_W (`LSU_ADDR_W - 2)

`endif

// ==== hw/lsu_pkg.sv ====
`default_nettype none

`include "lsu_params.svh"

// types seen by the load/store unit and its RAM.
package lsu_pkg;

    typedef logic [`LSU_ADDR_W-1:0] addr_t;  // byte address.
    typedef logic [`LSU_WIDX_W-1:0] widx_t;  // word index into the RAM.
    typedef logic [31:0]            data_t;
    typedef logic [3:0]             byte_en_t;

    // ********************
    // request / response
    // ********************
    typedef struct packed {
        logic                valid;
        rv_isa_pkg::opcode_t opcode;
        rv_isa_pkg::funct3_t funct3;
        addr_t               addr;
        data_t               wdata;
    } lsu_req_t;

    typedef struct packed {
        logic  valid;
        logic  is_load;
        logic  fault;
        data_t rdata;   // zero for stores and faults.
    } lsu_rsp_t;

    // write port of the data RAM.
    typedef struct packed {
        byte_en_t be;    // all zero means no write.
        widx_t    widx;
        data_t    wdata; // already steered into lanes.
    } ram_wr_t;

    // config write; the payload is the new protect limit.
    typedef struct packed {
        logic  we;
        addr_t wdata;
    } cfg_t;

endpackage

`default_nettype wire

// ==== hw/lsu_protect_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_protect_regs (
    input  logic           clk,
    input  logic           arst_n,
    input  lsu_pkg::cfg_t  cfg,
    input  logic           fault_pulse,
    output lsu_pkg::addr_t protect_limit,
    output lsu_pkg::data_t cfg_rdata
);

    localparam int PAD_W = 32 - `LSU_FCNT_W - `LSU_ADDR_W;

    lsu_pkg::addr_t          limit_q;
    logic [`LSU_FCNT_W-1:0]  fcnt_q;
    logic                    fcnt_full;

    // ********************
    // protect limit
    // ********************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            limit_q <= '0;  // zero disables protection.
        end else if (cfg.we) begin
            limit_q <= cfg.wdata;
        end
    end

    assign protect_limit = limit_q;

    // ********************
    // fault counter
    // ********************
    assign fcnt_full = &fcnt_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fcnt_q <= '0;
        end else if (fault_pulse && !fcnt_full) begin
            fcnt_q <= fcnt_q + 1'b1;  // sticks at all ones.
        end
    end

    // count on top, limit zero-extended below.
    assign cfg_rdata = {fcnt_q, {PAD_W{1'b0}}, limit_q};

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic              clk,
    input  logic              arst_n,
    input  lsu_pkg::lsu_req_t req,
    input  lsu_pkg::cfg_t     cfg,
    output lsu_pkg::lsu_rsp_t rsp,
    output lsu_pkg::data_t    cfg_rdata
);

    // ********************
    // internal nets
    // ********************
    lsu_pkg::ram_wr_t ram_wr;
    lsu_pkg::widx_t   ram_raddr;
    lsu_pkg::data_t   ram_rdata;
    lsu_pkg::addr_t   protect_limit;
    logic             fault_pulse;  // one per faulting request.

    // lane steering, extension and fault checks.
    lsu_lane_align u_align (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (req),
        .protect_limit (protect_limit),
        .ram_wr        (ram_wr),
        .ram_raddr     (ram_raddr),
        .ram_rdata     (ram_rdata),
        .rsp           (rsp),
        .fault_pulse   (fault_pulse)
    );

    // limit register and fault count.
    lsu_protect_regs u_regs (
        .clk           (clk),
        .arst_n        (arst_n),
        .cfg           (cfg),
        .fault_pulse   (fault_pulse),
        .protect_limit (protect_limit),
        .cfg_rdata     (cfg_rdata)
    );

    data_ram u_ram (
        .clk   (clk),
        .wr    (ram_wr),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

// RV32 load/store encodings.
package rv_isa_pkg;

    // ********************
    // major opcodes
    // ********************
    typedef logic [6:0] opcode_t;

    localparam opcode_t OP_LOAD  = 7'b0000011;
    localparam opcode_t OP_STORE = 7'b0100011;

    // ********************
    // funct3 fields
    // ********************
    typedef logic [2:0] funct3_t;

    // bit 2 picks zero extension on loads.
    localparam int F3_UNSIGNED_BIT = 2;

    // low two bits give the access size.
    typedef logic [1:0] size_t;

    localparam size_t SZ_BYTE = 2'b00;
    localparam size_t SZ_HALF = 2'b01;
    localparam size_t SZ_WORD = 2'b10;

endpackage

`default_nettype wire
